//--- verilog/capture_dma_params.svh
`ifndef CAPTURE_DMA_PARAMS_SVH
`define CAPTURE_DMA_PARAMS_SVH

// sample fifo storage, in 32-bit words
`define CD_FIFO_DEPTH 64

// fifo pointer width, log2 of the depth
`define CD_FIFO_AW 6

// largest axi len value, 16 beats
`define CD_MAX_BURST_LEN 15

// word address, not byte address
`define CD_ADDR_W 32

`endif

//--- verilog/capture_pkg.sv
`include "capture_dma_params.svh"

package capture_pkg;

    typedef logic [31:0] sample_t;
    typedef logic [`CD_ADDR_W-1:0] word_addr_t;  // counts words
    typedef logic [7:0] burst_len_t;             // beats minus one
    typedef logic [`CD_FIFO_AW:0] fifo_level_t;  // 0 .. depth

    typedef enum logic [3:0] {
        FIRST_LOAD,
        IDLE,
        LOAD_BURST,
        WR_ADDR,
        WR_DATA,
        WR_RESP,
        WR_ADDR_END,  // first part of a split burst, up to end_addr
        WR_DATA_END,
        WR_RESP_END
    } dma_state_t;

endpackage

//--- verilog/axi_wr_pkg.sv
package axi_wr_pkg;

    import capture_pkg::*;

    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    typedef struct packed {
        logic [1:0] id;
        word_addr_t addr;
        burst_len_t len;
        logic [1:0] burst;
    } axi_aw_t;

    typedef struct packed {
        sample_t    data;
        logic [3:0] strb;
        logic       last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] id;
        logic [1:0] resp;
    } axi_b_t;

endpackage

//--- verilog/rstn_sync.sv
`timescale 1ns/1ps

module rstn_sync (
    input  logic clk,
    input  logic rstn,
    output logic dma_rstn_sync
);

    logic rstn_meta;

    // assert at once, release two edges later
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rstn_meta     <= 1'b0;
            dma_rstn_sync <= 1'b0;
        end else begin
            rstn_meta     <= 1'b1;
            dma_rstn_sync <= rstn_meta;
        end
    end

endmodule

//--- verilog/sample_fifo.sv
`timescale 1ns/1ps
`include "capture_dma_params.svh"

module sample_fifo
    import capture_pkg::*;
(
    input  logic       clk,
    input  logic       dma_rstn_sync,
    input  logic       sample_valid,
    input  sample_t    sample,
    input  logic       pop,
    input  logic       burst_ready,
    output sample_t    pop_data,
    output logic       avail,
    output logic       overflow,
    output logic       burst_valid,
    output burst_len_t burst_len
);

    sample_t                mem [`CD_FIFO_DEPTH];
    logic [`CD_FIFO_AW-1:0] wr_ptr;
    logic [`CD_FIFO_AW-1:0] rd_ptr;
    fifo_level_t            level;
    fifo_level_t            reserved;  // promised to the dma, not popped yet
    fifo_level_t            free;
    logic                   full;
    logic                   push;
    logic                   do_pop;

    assign full     = (level == fifo_level_t'(`CD_FIFO_DEPTH));
    assign push     = sample_valid && !full;
    assign overflow = sample_valid && full;  // word dropped
    assign avail    = (level != '0);
    assign do_pop   = pop && avail;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= sample;
        end
    end

    always_ff @(posedge clk or negedge dma_rstn_sync) begin
        if (!dma_rstn_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // dma waiting again means leftovers of a restarted burst are free
    always_ff @(posedge clk or negedge dma_rstn_sync) begin
        if (!dma_rstn_sync) begin
            reserved <= '0;
        end else if (burst_valid && burst_ready) begin
            reserved <= fifo_level_t'(burst_len) + 1'b1;
        end else if (burst_ready) begin
            reserved <= '0;
        end else if (do_pop && reserved != '0) begin
            reserved <= reserved - 1'b1;
        end
    end

    assign free        = level - reserved;
    assign burst_valid = (free != '0);
    assign burst_len   = (free > fifo_level_t'(`CD_MAX_BURST_LEN)) ?
                         burst_len_t'(`CD_MAX_BURST_LEN) : burst_len_t'(free - 1'b1);

endmodule

//--- verilog/axi_write_dma.sv
`timescale 1ns/1ps

module axi_write_dma
    import capture_pkg::*;
    import axi_wr_pkg::*;
(
    input  logic       clk,
    input  logic       dma_rstn_sync,
    input  word_addr_t start_addr,
    input  word_addr_t end_addr,
    input  logic       capture_on,
    input  logic       capture_rst,
    input  logic       burst_valid,
    output logic       burst_ready,
    input  burst_len_t burst_len,
    input  logic       avail,
    output logic       pop,
    input  sample_t    pop_data,
    output axi_aw_t    aw,
    output logic       aw_valid,
    input  logic       aw_ready,
    output axi_w_t     w,
    output logic       w_valid,
    input  logic       w_ready,
    input  axi_b_t     b,
    input  logic       b_valid,
    output logic       b_ready
);

    dma_state_t state;
    dma_state_t state_nxt;
    word_addr_t wr_addr;
    word_addr_t next_addr;
    burst_len_t wr_len;
    burst_len_t offer_len;  // whole offer, second part of a split is the rest
    burst_len_t beat_cnt;
    logic       rst_seen;   // capture_rst seen, finish without popping
    logic       offer_take;
    logic       aw_take;
    logic       w_take;
    logic       b_take;
    logic       data_phase;
    logic       need_split;
    logic       restart;

    assign offer_take = burst_valid && burst_ready;
    assign aw_take    = aw_valid && aw_ready;
    assign w_take     = w_valid && w_ready;
    assign b_take     = b_valid && b_ready;
    assign restart    = rst_seen || capture_rst;
    assign need_split = (wr_addr + word_addr_t'(burst_len)) > end_addr;
    assign next_addr  = wr_addr + word_addr_t'(wr_len) + 1'b1;

    always_ff @(posedge clk or negedge dma_rstn_sync) begin
        if (!dma_rstn_sync) begin
            state <= FIRST_LOAD;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            FIRST_LOAD: if (capture_on && !capture_rst) state_nxt = LOAD_BURST;
            IDLE: begin
                if (restart) state_nxt = FIRST_LOAD;
                else if (capture_on) state_nxt = LOAD_BURST;
            end
            LOAD_BURST: begin
                if (capture_rst) state_nxt = FIRST_LOAD;
                else if (offer_take) state_nxt = need_split ? WR_ADDR_END : WR_ADDR;
            end
            WR_ADDR:     if (aw_take) state_nxt = WR_DATA;
            WR_DATA:     if (w_take && w.last) state_nxt = WR_RESP;
            WR_RESP:     if (b_take) state_nxt = restart ? FIRST_LOAD : IDLE;
            WR_ADDR_END: if (aw_take) state_nxt = WR_DATA_END;
            WR_DATA_END: if (w_take && w.last) state_nxt = WR_RESP_END;
            // second part restarts at the ring base
            WR_RESP_END: if (b_take) state_nxt = restart ? FIRST_LOAD : WR_ADDR;
            default:     state_nxt = FIRST_LOAD;
        endcase
    end

    always_ff @(posedge clk or negedge dma_rstn_sync) begin
        if (!dma_rstn_sync) begin
            rst_seen <= 1'b0;
        end else if (capture_rst) begin
            rst_seen <= 1'b1;
        end else if (state == FIRST_LOAD) begin
            rst_seen <= 1'b0;
        end
    end

    // ring pointer and burst lengths
    always_ff @(posedge clk or negedge dma_rstn_sync) begin
        if (!dma_rstn_sync) begin
            wr_addr   <= '0;
            wr_len    <= '0;
            offer_len <= '0;
        end else begin
            if (state == FIRST_LOAD && state_nxt == LOAD_BURST) begin
                wr_addr <= start_addr;
            end else if (state == WR_RESP && b_take) begin
                wr_addr <= (next_addr > end_addr) ? start_addr : next_addr;
            end else if (state == WR_RESP_END && b_take) begin
                wr_addr <= start_addr;
            end

            if (state == LOAD_BURST && offer_take) begin
                offer_len <= burst_len;
                wr_len    <= need_split ? burst_len_t'(end_addr - wr_addr) : burst_len;
            end else if (state == WR_RESP_END && b_take) begin
                wr_len <= offer_len - (wr_len + 1'b1);
            end
        end
    end

    always_ff @(posedge clk or negedge dma_rstn_sync) begin
        if (!dma_rstn_sync) begin
            beat_cnt <= '0;
        end else if (aw_take) begin
            beat_cnt <= wr_len;
        end else if (w_take && beat_cnt != '0) begin
            beat_cnt <= beat_cnt - 1'b1;
        end
    end

    assign data_phase  = (state == WR_DATA) || (state == WR_DATA_END);
    assign burst_ready = (state == LOAD_BURST) && capture_on && !capture_rst;

    assign aw_valid = (state == WR_ADDR) || (state == WR_ADDR_END);
    assign aw.id    = 2'd0;
    assign aw.addr  = wr_addr;
    assign aw.len   = wr_len;
    assign aw.burst = AXI_BURST_INCR;

    assign w_valid = data_phase && avail;
    assign w.data  = pop_data;
    assign w.strb  = 4'hf;
    assign w.last  = (beat_cnt == '0);
    assign pop     = w_take && !rst_seen;  // a restarted burst leaves its words queued

    assign b_ready = (state == WR_RESP) || (state == WR_RESP_END);  // resp code not checked

endmodule

//--- verilog/capture_dma_top.sv
`timescale 1ns/1ps

module capture_dma_top
    import capture_pkg::*;
    import axi_wr_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       sample_valid,
    input  sample_t    sample,
    input  logic       capture_on,
    input  logic       capture_rst,
    input  word_addr_t start_addr,
    input  word_addr_t end_addr,
    output logic       overflow,
    output axi_aw_t    aw,
    output logic       aw_valid,
    input  logic       aw_ready,
    output axi_w_t     w,
    output logic       w_valid,
    input  logic       w_ready,
    input  axi_b_t     b,
    input  logic       b_valid,
    output logic       b_ready
);

    logic       dma_rstn_sync;
    logic       pop;
    logic       avail;
    sample_t    pop_data;
    logic       burst_valid;
    logic       burst_ready;
    burst_len_t burst_len;

    rstn_sync rstn_sync_i (
        .clk           (clk),
        .rstn          (rstn),
        .dma_rstn_sync (dma_rstn_sync)
    );

    sample_fifo sample_fifo_i (
        .clk           (clk),
        .dma_rstn_sync (dma_rstn_sync),
        .sample_valid  (sample_valid),
        .sample        (sample),
        .pop           (pop),
        .burst_ready   (burst_ready),
        .pop_data      (pop_data),
        .avail         (avail),
        .overflow      (overflow),
        .burst_valid   (burst_valid),
        .burst_len     (burst_len)
    );

    axi_write_dma axi_write_dma_i (
        .clk           (clk),
        .dma_rstn_sync (dma_rstn_sync),
        .start_addr    (start_addr),
        .end_addr      (end_addr),
        .capture_on    (capture_on),
        .capture_rst   (capture_rst),
        .burst_valid   (burst_valid),
        .burst_ready   (burst_ready),
        .burst_len     (burst_len),
        .avail         (avail),
        .pop           (pop),
        .pop_data      (pop_data),
        .aw            (aw),
        .aw_valid      (aw_valid),
        .aw_ready      (aw_ready),
        .w             (w),
        .w_valid       (w_valid),
        .w_ready       (w_ready),
        .b             (b),
        .b_valid       (b_valid),
        .b_ready       (b_ready)
    );

endmodule

//--- tests/capture_dma_asserts.sv
`timescale 1ns/1ps

module capture_dma_asserts
    import capture_pkg::*;
    import axi_wr_pkg::*;
(
    input logic       clk,
    input logic       dma_rstn_sync,
    input word_addr_t end_addr,
    input axi_aw_t    aw,
    input logic       aw_valid,
    input logic       aw_ready,
    input axi_w_t     w,
    input logic       w_valid,
    input logic       w_ready
);

    burst_len_t cur_len;
    burst_len_t beat_idx;  // beats taken since the last aw

    always_ff @(posedge clk or negedge dma_rstn_sync) begin
        if (!dma_rstn_sync) begin
            cur_len  <= '0;
            beat_idx <= '0;
        end else if (aw_valid && aw_ready) begin
            cur_len  <= aw.len;
            beat_idx <= '0;
        end else if (w_valid && w_ready) begin
            beat_idx <= beat_idx + 1'b1;
        end
    end

    aw_hold: assert property (@(posedge clk) disable iff (!dma_rstn_sync)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("aw_valid dropped or aw changed before acceptance");

    w_hold: assert property (@(posedge clk) disable iff (!dma_rstn_sync)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("w_valid dropped or w changed before acceptance");

    last_beat: assert property (@(posedge clk) disable iff (!dma_rstn_sync)
        w_valid |-> (w.last == (beat_idx == cur_len)))
        else $error("w.last not on beat len plus one");

    ring_end: assert property (@(posedge clk) disable iff (!dma_rstn_sync)
        aw_valid |-> (aw.addr + word_addr_t'(aw.len)) <= end_addr)
        else $error("burst passes end_addr");

endmodule

//--- tests/capture_dma_checker.sv
`timescale 1ns/1ps
`include "capture_dma_params.svh"

module capture_dma_checker
    import capture_pkg::*;
    import axi_wr_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       sample_valid,
    input  sample_t    sample,
    input  logic       overflow,
    input  logic       capture_on,
    input  logic       capture_rst,
    input  word_addr_t start_addr,
    input  word_addr_t end_addr,
    input  axi_aw_t    aw,
    input  logic       aw_valid,
    input  logic       aw_ready,
    input  axi_w_t     w,
    input  logic       w_valid,
    input  logic       w_ready,
    input  logic       b_valid,
    input  logic       b_ready,
    output int         errors,
    output int         pending,
    output int         split_cnt,
    output int         ovf_cnt
);

    sample_t    exp_q[$];
    sample_t    exp;
    word_addr_t ptr;       // expected address of the next burst
    word_addr_t nxt;
    logic       discard;   // burst cut by capture_rst, beats carry no samples
    logic       mid;
    logic       on_q;
    logic       b_take_q;
    logic       aw_valid_q;
    logic       ovf_exp;   // model fifo full on a strobe

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
        $display("FAIL t=%0t %s got %h expected %h", $time, name, got, want);
        errors++;
    endtask

    task automatic problem(input string what);
        $display("ERROR t=%0t %s", $time, what);
        errors++;
    endtask

    // all handshakes are stable here, inputs move just after posedge
    always @(negedge clk) begin
        if (!rstn) begin
            exp_q.delete();
            ptr        = start_addr;
            discard    = 1'b0;
            mid        = 1'b0;
            on_q       = 1'b0;
            b_take_q   = 1'b0;
            aw_valid_q = 1'b0;
        end else begin
            // queued samples are exactly the words held in the fifo
            ovf_exp = sample_valid && (exp_q.size() == `CD_FIFO_DEPTH);
            if (overflow !== ovf_exp) mismatch("overflow", 32'(overflow), 32'(ovf_exp));
            if (sample_valid && !ovf_exp) exp_q.push_back(sample);
            if (ovf_exp) ovf_cnt++;

            if (aw_valid && !aw_valid_q) begin
                if (b_take_q) begin  // second half of a split
                    split_cnt++;
                    if (aw.addr !== start_addr) mismatch("split aw.addr", aw.addr, start_addr);
                end else if (!on_q) begin
                    problem("aw_valid raised while capture was paused");
                end
            end

            if (aw_valid && aw_ready) begin
                if (!discard) begin
                    if (aw.addr !== ptr) mismatch("aw.addr", aw.addr, ptr);
                    if (aw.len > burst_len_t'(`CD_MAX_BURST_LEN)) problem("aw.len above maximum");
                    if (aw.burst !== AXI_BURST_INCR) mismatch("aw.burst", 32'(aw.burst), 32'd1);
                    if (aw.id !== 2'd0) mismatch("aw.id", 32'(aw.id), 32'd0);
                    nxt = ptr + word_addr_t'(aw.len) + 1'b1;
                    ptr = (nxt > end_addr) ? start_addr : nxt;
                end
                mid = 1'b1;
            end

            if (w_valid && w_ready && !discard) begin
                if (w.strb !== 4'hf) mismatch("w.strb", 32'(w.strb), 32'hf);
                if (exp_q.size() == 0) begin
                    problem("write beat with no sample left to send");
                end else begin
                    exp = exp_q.pop_front();
                    if (w.data !== exp) mismatch("w.data", w.data, exp);
                end
            end

            if (b_valid && b_ready) begin
                mid     = 1'b0;
                discard = 1'b0;
            end
            if (capture_rst) begin
                ptr = start_addr;
                if (aw_valid || mid) discard = 1'b1;
            end

            on_q       = capture_on;
            b_take_q   = b_valid && b_ready;
            aw_valid_q = aw_valid;
        end
        pending = exp_q.size();
    end

endmodule

//--- tests/capture_dma_tb.sv
`timescale 1ns/1ps

module capture_dma_tb
    import capture_pkg::*;
    import axi_wr_pkg::*;
();

    localparam word_addr_t RING_START = 32'h100;
    localparam word_addr_t RING_END   = 32'h124;  // 37 words, bursts often split
    localparam int TOTAL_SAMPLES = 960;
    localparam int MAX_GAP       = 3;

    logic clk, rstn, sample_valid, capture_on, capture_rst, overflow;
    sample_t sample;
    word_addr_t start_addr, end_addr;
    axi_aw_t aw;
    axi_w_t w;
    axi_b_t b;
    logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    int chk_errors, chk_pending, chk_splits, chk_ovf;

    logic [31:0] lfsr = 32'h63c5_5f1f;
    logic [31:0] ready_thr;
    sample_t next_sample;
    int outstanding, ntests, nfail, err_base, cnt_base;

    capture_dma_top capture_dma_top_i (.*);

    capture_dma_checker chk_i (
        .clk(clk), .rstn(rstn), .sample_valid(sample_valid), .sample(sample),
        .overflow(overflow), .capture_on(capture_on), .capture_rst(capture_rst),
        .start_addr(start_addr), .end_addr(end_addr), .aw(aw), .aw_valid(aw_valid),
        .aw_ready(aw_ready), .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b_valid(b_valid), .b_ready(b_ready), .errors(chk_errors),
        .pending(chk_pending), .split_cnt(chk_splits), .ovf_cnt(chk_ovf)
    );

    bind axi_write_dma capture_dma_asserts asserts_i (
        .clk(clk), .dma_rstn_sync(dma_rstn_sync), .end_addr(end_addr), .aw(aw),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .w(w), .w_valid(w_valid), .w_ready(w_ready)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // axi slave, handshakes sampled mid cycle
    initial begin
        logic last_take, b_take;
        forever begin
            @(negedge clk);
            last_take = w_valid && w_ready && w.last;
            b_take    = b_valid && b_ready;
            @(posedge clk);
            #1;
            if (last_take) outstanding++;
            if (b_take) begin
                b_valid = 1'b0;
                outstanding--;
            end
            aw_ready = rand_bits(8) < ready_thr;
            w_ready  = rand_bits(8) < ready_thr;
            if (!b_valid && outstanding > 0 && rand_bits(2) == 2'd0) b_valid = 1'b1;
        end
    end

    initial begin
        #(TOTAL_SAMPLES * MAX_GAP * 20 * 8);
        $display("watchdog expired, the DMA stopped making progress");
        $display("TESTS FAILED");
        $finish;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic send_samples(input int n, input int max_gap);
        int gap;
        for (int i = 0; i < n; i++) begin
            gap = int'(rand_bits(2));
            if (gap > max_gap) gap = max_gap;
            repeat (gap) tick();
            sample_valid = 1'b1;
            sample       = next_sample;
            next_sample++;
            tick();
            sample_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        while (chk_pending != 0 || aw_valid || w_valid || b_ready) tick();
        repeat (4) tick();
    endtask

    task automatic pulse_restarts(input int n);
        for (int i = 0; i < n; i++) begin
            repeat (20 + int'(rand_bits(5))) tick();
            while (!w_valid) tick();  // land inside a burst
            capture_rst = 1'b1;
            tick();
            capture_rst = 1'b0;
        end
    endtask

    task automatic end_test(input string name, input logic extra_ok);
        ntests++;
        if (chk_errors == err_base && extra_ok) begin
            $display("test %0d %s: ok", ntests, name);
        end else begin
            $display("test %0d %s: bad, %0d errors", ntests, name, chk_errors - err_base);
            nfail++;
        end
        err_base = chk_errors;
    endtask

    initial begin
        rstn = 1'b0;
        sample_valid = 1'b0;
        sample = '0;
        capture_on = 1'b0;
        capture_rst = 1'b0;
        start_addr = RING_START;
        end_addr = RING_END;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        b = '0;
        ready_thr = 32'd230;
        next_sample = 32'h1000;
        repeat (4) tick();
        rstn = 1'b1;
        repeat (4) tick();

        capture_on = 1'b1;
        send_samples(160, 3);
        wait_drain();
        end_test("data order", 1'b1);

        send_samples(160, 1);
        wait_drain();
        end_test("ring addressing", 1'b1);

        cnt_base = chk_splits;
        send_samples(160, 0);
        wait_drain();
        end_test("boundary split", chk_splits > cnt_base);

        send_samples(60, 1);
        capture_on = 1'b0;
        send_samples(40, 2);
        repeat (50) tick();
        capture_on = 1'b1;
        send_samples(60, 1);
        wait_drain();
        end_test("pause and resume", 1'b1);

        fork
            send_samples(160, 2);
            pulse_restarts(3);
        join
        wait_drain();
        end_test("restart", 1'b1);

        ready_thr = 32'd60;
        cnt_base = chk_ovf;
        capture_on = 1'b0;
        send_samples(80, 0);  // fills the fifo past its depth
        capture_on = 1'b1;
        send_samples(80, 1);
        wait_drain();
        end_test("back-pressure and overflow", chk_ovf > cnt_base);

        $display("summary: %0d tests, %0d bad, %0d checker errors", ntests, nfail, chk_errors);
        if (nfail == 0 && chk_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- capture_dma.f
+incdir+verilog
verilog/capture_pkg.sv
verilog/axi_wr_pkg.sv
verilog/rstn_sync.sv
verilog/sample_fifo.sv
verilog/axi_write_dma.sv
verilog/capture_dma_top.sv
tests/capture_dma_asserts.sv
tests/capture_dma_checker.sv
tests/capture_dma_tb.sv

//--- Makefile
TOP := capture_dma_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f capture_dma.f

obj_dir/V$(TOP): capture_dma.f verilog/*.sv verilog/*.svh tests/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f capture_dma.f

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
